/* common/llc_cfg.svh */
// llc data storage configuration: way count, array depth and word width
`ifndef LLC_CFG_SVH
`define LLC_CFG_SVH

// ------------------------------------------------------------
// array geometry
// ------------------------------------------------------------

// set associativity, one data macro per way
`define LLC_NUM_WAYS 4

// cache lines held in each way
`define LLC_NUM_LINES 16

// data words per cache line
`define LLC_NUM_BLOCKS 4

// ------------------------------------------------------------
// word format
// ------------------------------------------------------------

// bits per stored data word
`define LLC_DATA_WIDTH 64

// one byte enable per data byte
`define LLC_STRB_WIDTH (`LLC_DATA_WIDTH / 8)

`endif

/* common/llc_pkg.sv */
// llc data storage types: address fields, unit tags and way request/result structs
`include "llc_cfg.svh"

package llc_pkg;

  // ------------------------------------------------------------
  // field widths
  // ------------------------------------------------------------

  // bits to index a line inside one way
  localparam int unsigned line_aw = $clog2(`LLC_NUM_LINES);
  // bits to select a word inside one line
  localparam int unsigned blk_aw  = $clog2(`LLC_NUM_BLOCKS);

  // one-hot way select
  typedef logic [`LLC_NUM_WAYS-1:0]   way_ind_t;
  // line index
  typedef logic [line_aw-1:0]         line_addr_t;
  // word offset inside a line
  typedef logic [blk_aw-1:0]          blk_offset_t;
  // macro address, index in the upper bits
  typedef logic [line_aw+blk_aw-1:0]  sram_addr_t;
  // one stored word
  typedef logic [`LLC_DATA_WIDTH-1:0] data_t;
  // byte enables for one word
  typedef logic [`LLC_STRB_WIDTH-1:0] strb_t;

  // ------------------------------------------------------------
  // cache units issuing data accesses
  // ------------------------------------------------------------

  // only evict and read units get read results back
  typedef enum logic [1:0] {
    EVICT_UNIT  = 2'd0,
    REFILL_UNIT = 2'd1,
    READ_UNIT   = 2'd2,
    WRITE_UNIT  = 2'd3
  } cache_unit_e;

  // request into the ways
  typedef struct packed {
    cache_unit_e cache_unit;
    way_ind_t    way_ind;
    line_addr_t  line_addr;
    blk_offset_t blk_offset;
    logic        we;
    data_t       data;
    strb_t       strb;
  } way_inp_t;

  // read result out of a way, tagged with the requesting unit
  typedef struct packed {
    cache_unit_e cache_unit;
    data_t       data;
  } way_oup_t;

endpackage

/* data_ways/llc_data_sram.sv */
// llc data macro model: single port word memory with byte writes and registered read
`timescale 1ns/1ns
`include "llc_cfg.svh"

module llc_data_sram (
  input  logic               clk_i,
  input  logic               rst_n_i,
  // access request
  input  logic               req_i,
  input  logic               we_i,
  input  llc_pkg::sram_addr_t addr_i,
  input  llc_pkg::data_t     wdata_i,
  input  llc_pkg::strb_t     be_i,
  // read port, valid the cycle after a read request
  output llc_pkg::data_t     rdata_o
);

  // one word per line and block
  localparam int unsigned num_words = `LLC_NUM_LINES * `LLC_NUM_BLOCKS;

  // storage array
  llc_pkg::data_t mem [0:num_words-1];
  // read register, keeps its value between reads
  llc_pkg::data_t rdata_q;

  // ------------------------------------------------------------
  // array access
  // ------------------------------------------------------------

  // byte masked write
  always_ff @(posedge clk_i) begin
    if (req_i && we_i) begin
      for (int unsigned b = 0; b < `LLC_STRB_WIDTH; b++) begin
        if (be_i[b]) begin
          mem[addr_i][b*8 +: 8] <= wdata_i[b*8 +: 8];
        end
      end
    end
  end

  // read captures the addressed word, writes leave it alone
  always_ff @(posedge clk_i) begin
    if (req_i && !we_i) begin
      rdata_q <= mem[addr_i];
    end
  end

  assign rdata_o = rdata_q;

  // address must be known whenever the macro is accessed
  a_addr_known: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    req_i |-> !$isunknown(addr_i))
    else $error("llc_data_sram: unknown address on request");

endmodule

/* data_ways/llc_data_way.sv */
// llc data way: drives one data macro and holds its read result until taken
`timescale 1ns/1ns

module llc_data_way (
  input  logic              clk_i,
  input  logic              rst_n_i,
  // request from the router
  input  llc_pkg::way_inp_t inp_i,
  input  logic              inp_valid_i,
  output logic              inp_ready_o,
  // read result towards the router
  output llc_pkg::way_oup_t out_o,
  output logic              out_valid_o,
  input  logic              out_ready_i
);

  // macro address, index above offset
  llc_pkg::sram_addr_t   sram_addr;
  // macro read data
  llc_pkg::data_t        sram_rdata;

  // handshake helpers
  logic                  accept;
  logic                  take_res;
  // request asks for a result on an output port
  logic                  res_req;

  // pending result and its owner
  logic                  res_valid_q;
  llc_pkg::cache_unit_e  unit_q;

  assign sram_addr = {inp_i.line_addr, inp_i.blk_offset};

  // ------------------------------------------------------------
  // handshake control
  // ------------------------------------------------------------

  // result leaves the way this cycle
  assign take_res = res_valid_q & out_ready_i;

  // free when nothing pending or the pending result goes out now
  assign inp_ready_o = ~res_valid_q | out_ready_i;
  assign accept      = inp_valid_i & inp_ready_o;

  // reads of the evict and read units come back, anything else is dropped
  assign res_req = ~inp_i.we &
                   ((inp_i.cache_unit == llc_pkg::EVICT_UNIT) |
                    (inp_i.cache_unit == llc_pkg::READ_UNIT));

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      res_valid_q <= 1'b0;
      unit_q      <= llc_pkg::EVICT_UNIT;
    end else if (accept) begin
      // new access replaces any result taken this cycle
      res_valid_q <= res_req;
      unit_q      <= inp_i.cache_unit;
    end else if (take_res) begin
      res_valid_q <= 1'b0;
    end
  end

  // ------------------------------------------------------------
  // data macro
  // ------------------------------------------------------------

  // macro is only touched on an accepted request, so data holds while stalled
  llc_data_sram i_data_sram (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .req_i   (accept),
    .we_i    (inp_i.we),
    .addr_i  (sram_addr),
    .wdata_i (inp_i.data),
    .be_i    (inp_i.strb),
    .rdata_o (sram_rdata)
  );

  // result struct, macro data lines up with the valid flag
  assign out_o.cache_unit = unit_q;
  assign out_o.data       = sram_rdata;
  assign out_valid_o      = res_valid_q;

  // stalled result keeps unit and macro data
  a_out_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    out_valid_o && !out_ready_i |=> $stable(out_o))
    else $error("llc_data_way: result changed under back-pressure");

  // a pending result always belongs to a unit with an output port
  a_out_unit: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    out_valid_o |-> (out_o.cache_unit == llc_pkg::EVICT_UNIT) ||
                    (out_o.cache_unit == llc_pkg::READ_UNIT))
    else $error("llc_data_way: result for a unit without output port");

endmodule

/* data_ways/llc_way_router.sv */
// llc way router: steers requests to one way and way results to the evict or read port
`timescale 1ns/1ns
`include "llc_cfg.svh"

module llc_way_router (
  input  logic                                     clk_i,
  input  logic                                     rst_n_i,
  // request from the cache units
  input  llc_pkg::way_inp_t                        inp_i,
  input  logic                                     inp_valid_i,
  output logic                                     inp_ready_o,
  // request side of the ways
  output llc_pkg::way_ind_t                        way_valid_o,
  input  llc_pkg::way_ind_t                        way_ready_i,
  // result side of the ways
  input  llc_pkg::way_oup_t [`LLC_NUM_WAYS-1:0]    way_res_i,
  input  llc_pkg::way_ind_t                        way_res_valid_i,
  output llc_pkg::way_ind_t                        way_res_ready_o,
  // eviction unit result
  output llc_pkg::way_oup_t                        evict_o,
  output logic                                     evict_valid_o,
  input  logic                                     evict_ready_i,
  // hit read unit result
  output llc_pkg::way_oup_t                        read_o,
  output logic                                     read_valid_o,
  input  logic                                     read_ready_i
);

  // pending results per unit
  llc_pkg::way_ind_t evict_req;
  llc_pkg::way_ind_t read_req;
  // winning way per unit, one-hot or zero
  llc_pkg::way_ind_t evict_sel;
  llc_pkg::way_ind_t read_sel;

  // lowest set bit wins
  function automatic llc_pkg::way_ind_t pick_lowest(input llc_pkg::way_ind_t req);
    llc_pkg::way_ind_t sel;
    logic              found;
    sel   = '0;
    found = 1'b0;
    for (int unsigned w = 0; w < `LLC_NUM_WAYS; w++) begin
      if (req[w] && !found) begin
        sel[w] = 1'b1;
        found  = 1'b1;
      end
    end
    return sel;
  endfunction

  // and-or mux over the way results
  function automatic llc_pkg::way_oup_t mux_res(
    input llc_pkg::way_ind_t                     sel,
    input llc_pkg::way_oup_t [`LLC_NUM_WAYS-1:0] res
  );
    llc_pkg::way_oup_t out;
    out = '0;
    for (int unsigned w = 0; w < `LLC_NUM_WAYS; w++) begin
      if (sel[w]) begin
        out = out | res[w];
      end
    end
    return out;
  endfunction

  // ------------------------------------------------------------
  // request side
  // ------------------------------------------------------------

  // valid only towards the selected way
  assign way_valid_o = inp_valid_i ? inp_i.way_ind : '0;
  // ready of the selected way
  assign inp_ready_o = |(way_ready_i & inp_i.way_ind);

  // ------------------------------------------------------------
  // result side
  // ------------------------------------------------------------

  // sort pending results by owning unit
  always_comb begin
    evict_req = '0;
    read_req  = '0;
    for (int unsigned w = 0; w < `LLC_NUM_WAYS; w++) begin
      evict_req[w] = way_res_valid_i[w] &
                     (way_res_i[w].cache_unit == llc_pkg::EVICT_UNIT);
      read_req[w]  = way_res_valid_i[w] &
                     (way_res_i[w].cache_unit == llc_pkg::READ_UNIT);
    end
  end

  // fixed priority, way 0 first
  assign evict_sel = pick_lowest(evict_req);
  assign read_sel  = pick_lowest(read_req);

  assign evict_o       = mux_res(evict_sel, way_res_i);
  assign evict_valid_o = |evict_req;
  assign read_o        = mux_res(read_sel, way_res_i);
  assign read_valid_o  = |read_req;

  // each port's ready goes back only to its winner
  assign way_res_ready_o = (evict_sel & {`LLC_NUM_WAYS{evict_ready_i}}) |
                           (read_sel  & {`LLC_NUM_WAYS{read_ready_i}});

  // a request targets exactly one way
  a_way_onehot: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    inp_valid_i |-> $onehot(inp_i.way_ind))
    else $error("llc_way_router: way select not one-hot");

endmodule

/* data_ways/llc_data_ways.sv */
// llc data ways top: router in front of an array of data ways
`timescale 1ns/1ns
`include "llc_cfg.svh"

module llc_data_ways (
  input  logic              clk_i,
  input  logic              rst_n_i,
  // request from the cache units
  input  llc_pkg::way_inp_t inp_i,
  input  logic              inp_valid_i,
  output logic              inp_ready_o,
  // eviction unit result
  output llc_pkg::way_oup_t evict_o,
  output logic              evict_valid_o,
  input  logic              evict_ready_i,
  // hit read unit result
  output llc_pkg::way_oup_t read_o,
  output logic              read_valid_o,
  input  logic              read_ready_i
);

  // request handshake per way
  llc_pkg::way_ind_t                     way_valid;
  llc_pkg::way_ind_t                     way_ready;
  // result handshake per way
  llc_pkg::way_oup_t [`LLC_NUM_WAYS-1:0] way_res;
  llc_pkg::way_ind_t                     way_res_valid;
  llc_pkg::way_ind_t                     way_res_ready;

  // ------------------------------------------------------------
  // routing
  // ------------------------------------------------------------

  llc_way_router i_way_router (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .inp_i           (inp_i),
    .inp_valid_i     (inp_valid_i),
    .inp_ready_o     (inp_ready_o),
    .way_valid_o     (way_valid),
    .way_ready_i     (way_ready),
    .way_res_i       (way_res),
    .way_res_valid_i (way_res_valid),
    .way_res_ready_o (way_res_ready),
    .evict_o         (evict_o),
    .evict_valid_o   (evict_valid_o),
    .evict_ready_i   (evict_ready_i),
    .read_o          (read_o),
    .read_valid_o    (read_valid_o),
    .read_ready_i    (read_ready_i)
  );

  // ------------------------------------------------------------
  // way array
  // ------------------------------------------------------------

  // request bus shared by all ways, the valid picks the target
  for (genvar w = 0; w < `LLC_NUM_WAYS; w++) begin : g_way
    llc_data_way i_data_way (
      .clk_i       (clk_i),
      .rst_n_i     (rst_n_i),
      .inp_i       (inp_i),
      .inp_valid_i (way_valid[w]),
      .inp_ready_o (way_ready[w]),
      .out_o       (way_res[w]),
      .out_valid_o (way_res_valid[w]),
      .out_ready_i (way_res_ready[w])
    );
  end

endmodule

/* tb/llc_tb_clk.sv */
// testbench clock and reset: 40 ns clock, reset held low for the first cycles
`timescale 1ns/1ns

module llc_tb_clk (
  output logic clk_o,
  output logic rst_n_o
);

  // half of the 40 ns period
  localparam int unsigned half_period = 20;
  // rising edges seen with reset asserted
  localparam int unsigned rst_cycles  = 4;

  initial begin
    clk_o = 1'b0;
    forever begin
      #(half_period);
      clk_o = ~clk_o;
    end
  end

  // release lands between edges, like the other inputs
  initial begin
    rst_n_o = 1'b0;
    repeat (rst_cycles) @(posedge clk_o);
    #5;
    rst_n_o = 1'b1;
  end

endmodule

/* tb/llc_data_ways_tb.sv */
// llc data ways testbench: directed tests checked against a shadow copy of the ways
`timescale 1ns/1ns
`include "llc_cfg.svh"

module llc_data_ways_tb;

  // inputs change this long after the rising edge
  localparam int unsigned drive_dly = 5;
  // cycles before any wait gives up
  localparam int unsigned max_wait  = 40;

  logic              clk;
  logic              rst_n;
  llc_pkg::way_inp_t inp;
  logic              inp_valid;
  logic              inp_ready;
  llc_pkg::way_oup_t evict_res;
  logic              evict_valid;
  logic              evict_ready;
  llc_pkg::way_oup_t read_res;
  logic              read_valid;
  logic              read_ready;

  // expected array contents, way by line by block
  llc_pkg::data_t shadow [`LLC_NUM_WAYS][`LLC_NUM_LINES][`LLC_NUM_BLOCKS];

  llc_tb_clk i_tb_clk (
    .clk_o   (clk),
    .rst_n_o (rst_n)
  );

  llc_data_ways dut0 (
    .clk_i         (clk),
    .rst_n_i       (rst_n),
    .inp_i         (inp),
    .inp_valid_i   (inp_valid),
    .inp_ready_o   (inp_ready),
    .evict_o       (evict_res),
    .evict_valid_o (evict_valid),
    .evict_ready_i (evict_ready),
    .read_o        (read_res),
    .read_valid_o  (read_valid),
    .read_ready_i  (read_ready)
  );

  // ------------------------------------------------------------
  // failure and reference helpers
  // ------------------------------------------------------------

  task automatic stop_run(input string line);
    $display("%s", line);
    $display("ERRORS FOUND");
    $fatal(1, "stopping at the first failure");
  endtask

  task automatic value_error(input string msg);
    stop_run($sformatf("error at %0t ns: %s", $time, msg));
  endtask

  // byte lanes with the strobe set come from the new word
  function automatic llc_pkg::data_t merge_bytes(input llc_pkg::data_t old_w,
                                                 input llc_pkg::data_t new_w,
                                                 input llc_pkg::strb_t strb);
    llc_pkg::data_t res;
    res = old_w;
    for (int unsigned i = 0; i < `LLC_STRB_WIDTH; i++) begin
      if (strb[i]) begin
        res[i*8 +: 8] = new_w[i*8 +: 8];
      end
    end
    return res;
  endfunction

  function automatic llc_pkg::data_t rand_word();
    return {$urandom, $urandom};
  endfunction

  // ------------------------------------------------------------
  // request side
  // ------------------------------------------------------------

  // put a request on the bus, stays until accepted
  task automatic offer_req(input llc_pkg::cache_unit_e unit, input int unsigned w,
                           input int unsigned l, input int unsigned b, input logic we,
                           input llc_pkg::data_t data, input llc_pkg::strb_t strb);
    inp.cache_unit = unit;
    inp.way_ind    = llc_pkg::way_ind_t'(1) << w;
    inp.line_addr  = llc_pkg::line_addr_t'(l);
    inp.blk_offset = llc_pkg::blk_offset_t'(b);
    inp.we         = we;
    inp.data       = data;
    inp.strb       = strb;
    inp_valid      = 1'b1;
  endtask

  // ready sampled mid cycle, transfer on the following edge
  task automatic wait_accept();
    int unsigned cnt;
    cnt = 0;
    @(negedge clk);
    while (!inp_ready) begin
      cnt++;
      assert (cnt < max_wait) else stop_run("timeout: request never accepted by its way");
      @(negedge clk);
    end
    @(posedge clk);
    #(drive_dly);
    inp_valid = 1'b0;
  endtask

  task automatic write_word(input llc_pkg::cache_unit_e unit, input int unsigned w,
                            input int unsigned l, input int unsigned b,
                            input llc_pkg::data_t data, input llc_pkg::strb_t strb);
    offer_req(unit, w, l, b, 1'b1, data, strb);
    wait_accept();
    shadow[w][l][b] = merge_bytes(shadow[w][l][b], data, strb);
  endtask

  task automatic read_word(input llc_pkg::cache_unit_e unit, input int unsigned w,
                           input int unsigned l, input int unsigned b);
    offer_req(unit, w, l, b, 1'b0, '0, '0);
    wait_accept();
  endtask

  // ------------------------------------------------------------
  // result side
  // ------------------------------------------------------------

  // solo also requires the other port to be idle at that moment
  task automatic expect_result(input llc_pkg::cache_unit_e unit, input llc_pkg::data_t exp,
                               input logic solo);
    int unsigned       cnt;
    logic              evict_side;
    llc_pkg::way_oup_t res;
    evict_side  = (unit == llc_pkg::EVICT_UNIT);
    evict_ready = evict_side;
    read_ready  = !evict_side;
    cnt = 0;
    @(negedge clk);
    while (!(evict_side ? evict_valid : read_valid)) begin
      cnt++;
      assert (cnt < max_wait) else stop_run("timeout: no result on the expected port");
      @(negedge clk);
    end
    res = evict_side ? evict_res : read_res;
    assert (res.cache_unit == unit) else
      value_error($sformatf("result tagged unit %0d, expected %0d", res.cache_unit, unit));
    assert (res.data == exp) else
      value_error($sformatf("result data %h, expected %h", res.data, exp));
    assert (!solo || !(evict_side ? read_valid : evict_valid)) else
      value_error("result also valid on the other port");
    @(posedge clk);
    #(drive_dly);
    evict_ready = 1'b0;
    read_ready  = 1'b0;
  endtask

  task automatic check_no_result(input int unsigned cycles);
    repeat (cycles) begin
      @(negedge clk);
      assert (!evict_valid && !read_valid) else value_error("result valid with no read pending");
    end
    @(posedge clk);
    #(drive_dly);
  endtask

  // ------------------------------------------------------------
  // directed tests
  // ------------------------------------------------------------

  task automatic full_write_read();
    llc_pkg::data_t d;
    d = rand_word();
    write_word(llc_pkg::WRITE_UNIT, 2, 5, 1, d, '1);
    read_word(llc_pkg::READ_UNIT, 2, 5, 1);
    expect_result(llc_pkg::READ_UNIT, d, 1'b1);
  endtask

  task automatic partial_write_merge();
    llc_pkg::data_t d0;
    llc_pkg::data_t d1;
    llc_pkg::strb_t s;
    d0 = rand_word();
    d1 = rand_word();
    s  = llc_pkg::strb_t'(32'ha5a5_a5a5);
    write_word(llc_pkg::WRITE_UNIT, 1, 9, 3, d0, '1);
    write_word(llc_pkg::WRITE_UNIT, 1, 9, 3, d1, s);
    read_word(llc_pkg::READ_UNIT, 1, 9, 3);
    expect_result(llc_pkg::READ_UNIT, merge_bytes(d0, d1, s), 1'b1);
  endtask

  task automatic unit_routing();
    read_word(llc_pkg::EVICT_UNIT, 3, 0, 2);
    expect_result(llc_pkg::EVICT_UNIT, shadow[3][0][2], 1'b1);
    read_word(llc_pkg::READ_UNIT, 3, 0, 2);
    expect_result(llc_pkg::READ_UNIT, shadow[3][0][2], 1'b1);
    // writes and refill reads return nothing
    write_word(llc_pkg::WRITE_UNIT, 3, 0, 2, rand_word(), '1);
    check_no_result(3);
    read_word(llc_pkg::REFILL_UNIT, 3, 0, 2);
    check_no_result(3);
  endtask

  task automatic back_pressure();
    llc_pkg::way_oup_t held;
    read_word(llc_pkg::READ_UNIT, 0, 4, 0);
    // way 1 stays free while way 0 is stalled
    read_word(llc_pkg::READ_UNIT, 1, 4, 0);
    offer_req(llc_pkg::READ_UNIT, 0, 4, 0, 1'b0, '0, '0);
    @(negedge clk);
    held = read_res;
    assert (read_valid && held.data == shadow[0][4][0]) else
      value_error("way 0 result missing or wrong under back-pressure");
    repeat (4) begin
      @(negedge clk);
      assert (!inp_ready) else value_error("way 0 accepted a request while stalled");
      assert (read_res == held) else value_error("read result changed while stalled");
    end
    @(posedge clk);
    #(drive_dly);
    // held result and the waiting request go on the same edge
    read_ready = 1'b1;
    wait_accept();
    read_ready = 1'b0;
    expect_result(llc_pkg::READ_UNIT, shadow[0][4][0], 1'b0);
    expect_result(llc_pkg::READ_UNIT, shadow[1][4][0], 1'b0);
  endtask

  task automatic way_independence();
    llc_pkg::data_t d;
    for (int unsigned w = 0; w < `LLC_NUM_WAYS; w++) begin
      d = rand_word();
      d[7:0] = 8'(w);
      write_word(llc_pkg::WRITE_UNIT, w, 7, 2, d, '1);
    end
    for (int unsigned w = 0; w < `LLC_NUM_WAYS; w++) begin
      read_word(llc_pkg::READ_UNIT, w, 7, 2);
      expect_result(llc_pkg::READ_UNIT, shadow[w][7][2], 1'b1);
    end
  endtask

  // mixed writes, single reads and one read per unit in parallel
  task automatic random_traffic(input int unsigned ops);
    int unsigned          w;
    int unsigned          l;
    int unsigned          b;
    int unsigned          w2;
    llc_pkg::cache_unit_e unit;
    for (int unsigned i = 0; i < ops; i++) begin
      w = $urandom % `LLC_NUM_WAYS;
      l = $urandom % `LLC_NUM_LINES;
      b = $urandom % `LLC_NUM_BLOCKS;
      case ($urandom % 4)
        0: write_word(llc_pkg::WRITE_UNIT, w, l, b, rand_word(), llc_pkg::strb_t'($urandom));
        1: write_word(llc_pkg::REFILL_UNIT, w, l, b, rand_word(), llc_pkg::strb_t'($urandom));
        2: begin
          unit = ($urandom % 2 == 0) ? llc_pkg::EVICT_UNIT : llc_pkg::READ_UNIT;
          read_word(unit, w, l, b);
          expect_result(unit, shadow[w][l][b], 1'b1);
        end
        default: begin
          // second way differs, otherwise it stalls behind the first result
          w2 = (w + 1 + $urandom % (`LLC_NUM_WAYS - 1)) % `LLC_NUM_WAYS;
          read_word(llc_pkg::EVICT_UNIT, w, l, b);
          read_word(llc_pkg::READ_UNIT, w2, l, b);
          expect_result(llc_pkg::EVICT_UNIT, shadow[w][l][b], 1'b0);
          expect_result(llc_pkg::READ_UNIT, shadow[w2][l][b], 1'b0);
        end
      endcase
    end
  endtask

  // ------------------------------------------------------------
  // sequence
  // ------------------------------------------------------------

  initial begin
    int unsigned seed_val;
    int unsigned cnt;
    seed_val    = $urandom(32'ha024);
    inp         = '0;
    inp_valid   = 1'b0;
    evict_ready = 1'b0;
    read_ready  = 1'b0;
    cnt = 0;
    while (rst_n !== 1'b1) begin
      cnt++;
      assert (cnt < max_wait) else stop_run("timeout: reset was never released");
      @(posedge clk);
    end
    @(posedge clk);
    #(drive_dly);
    check_no_result(2);
    // known contents everywhere, pattern from way, line and block
    for (int unsigned w = 0; w < `LLC_NUM_WAYS; w++) begin
      for (int unsigned l = 0; l < `LLC_NUM_LINES; l++) begin
        for (int unsigned b = 0; b < `LLC_NUM_BLOCKS; b++) begin
          write_word(llc_pkg::WRITE_UNIT, w, l, b, {16'hc0de, 16'(w), 16'(l), 16'(b)}, '1);
        end
      end
    end
    full_write_read();
    partial_write_merge();
    unit_routing();
    back_pressure();
    way_independence();
    random_traffic(300);
    $display("NO ERRORS");
    $finish;
  end

endmodule

/* build.f */
+incdir+common
common/llc_pkg.sv
data_ways/llc_data_sram.sv
data_ways/llc_data_way.sv
data_ways/llc_way_router.sv
data_ways/llc_data_ways.sv
tb/llc_tb_clk.sv
tb/llc_data_ways_tb.sv

/* Makefile */
# verilator flow for the llc data ways
TOOL     := verilator
FLAGS    := --timing --assert --timescale 1ns/1ns
FILES    := build.f
TOP      := llc_data_ways_tb
RTL_TOP  := llc_data_ways
OBJ_DIR  := obj_dir
PASS_MSG := NO ERRORS

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) --lint-only $(FLAGS) -f $(FILES) --top-module $(RTL_TOP)

# pass only when the testbench prints the pass line
sim:
	$(TOOL) --binary $(FLAGS) -f $(FILES) --top-module $(TOP) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
